// ==== arcade_pkg.sv ====
// Shared stream types, ROM map and video timing constants, imported by every shell module
package arcade_pkg;

	////////////////////////////////////////////////////////////
	// Stream and memory payloads

	typedef struct packed {
		logic [17:0] addr;  // Byte address in download image
		logic [7:0]  data;
	} rom_byte_t;

	typedef struct packed {
		logic       pressed;
		logic [7:0] code;   // PS/2 set 2 scancode
	} key_event_t;

	typedef struct packed {
		logic        region; // 0 main, 1 sprite
		logic [14:0] addr;
		logic [15:0] data;   // Same byte in both lanes
		logic [1:0]  be;
	} rom_write_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
		logic start1;
		logic start2;
		logic coin;
	} buttons_t;

	typedef struct packed {
		logic [5:0] inp0;
		logic [5:0] inp1;
		logic [2:0] inp2;
		logic [7:0] dsw0;
	} cabinet_t;

	////////////////////////////////////////////////////////////
	// Download image layout

	localparam int main_base   = 'h00000;
	localparam int main_size   = 'h10000;
	localparam int sprite_base = 'h10000;
	localparam int sprite_size = 'h10000;
	localparam int rom_words   = 32768;

	////////////////////////////////////////////////////////////
	// Video timing in pixel clocks and lines

	localparam int pclk_div     = 8;  // 48 MHz down to 6 MHz
	localparam int h_total      = 384;
	localparam int v_total      = 264;
	localparam int h_active     = 256;
	localparam int v_active     = 224;
	localparam int h_sync_start = 304;
	localparam int h_sync_end   = 336;
	localparam int v_sync_start = 236;
	localparam int v_sync_end   = 240;

	// Cabinet key scancodes
	localparam logic [7:0] key_up     = 8'h75;
	localparam logic [7:0] key_down   = 8'h72;
	localparam logic [7:0] key_left   = 8'h6B;
	localparam logic [7:0] key_right  = 8'h74;
	localparam logic [7:0] key_coin   = 8'h76; // Esc
	localparam logic [7:0] key_start1 = 8'h05; // F1
	localparam logic [7:0] key_start2 = 8'h06; // F2
	localparam logic [7:0] key_fire1  = 8'h29; // Space
	localparam logic [7:0] key_fire2  = 8'h11; // Alt

endpackage

// ==== arcade_shell.sv ====
// Platform shell top level joining ROM download, cabinet controls and video timing to the core
`timescale 1ns/1ps

module arcade_shell (
	input  logic                   clock_48,
	input  logic                   rst,
	input  logic                   download,
	input  logic                   byte_valid,
	output logic                   byte_ready,
	input  arcade_pkg::rom_byte_t  byte_in,
	input  logic                   key_valid,
	output logic                   key_ready,
	input  arcade_pkg::key_event_t key,
	input  logic [7:0]             joy0,
	input  logic [7:0]             joy1,
	input  logic [31:0]            status,
	input  logic                   menu_reset,
	input  logic [15:0]            cpu_addr,
	output logic [7:0]             cpu_data,
	input  logic [14:0]            spr_addr,
	output logic [15:0]            spr_data,
	input  logic [11:0]            pixel_rgb,
	output arcade_pkg::cabinet_t   cabinet,
	output logic                   core_reset,
	output logic                   pclk_en,
	output logic [8:0]             hpos,
	output logic [8:0]             vpos,
	output logic                   hblank,
	output logic                   vblank,
	output logic                   hsync,
	output logic                   vsync,
	output logic [11:0]            rgb_out
);
	import arcade_pkg::*;

	rom_byte_t  byte_q;
	logic       byte_q_valid;
	logic       byte_q_ready;
	key_event_t key_q;
	logic       key_q_valid;
	logic       key_q_ready;
	logic       wr_valid;
	rom_write_t wr;
	logic       rom_loaded;
	buttons_t   buttons;

	////////////////////////////////////////////////////////////
	// ROM download path

	stream_skid #(.payload_t(rom_byte_t)) byte_skid (
		.clock_48  (clock_48),
		.rst       (rst),
		.in_valid  (byte_valid),
		.in_ready  (byte_ready),
		.in_data   (byte_in),
		.out_valid (byte_q_valid),
		.out_ready (byte_q_ready),
		.out_data  (byte_q)
	);

	rom_loader loader (
		.clock_48   (clock_48),
		.rst        (rst),
		.download   (download),
		.byte_valid (byte_q_valid),
		.byte_ready (byte_q_ready),
		.byte_in    (byte_q),
		.wr_valid   (wr_valid),
		.wr         (wr),
		.rom_loaded (rom_loaded)
	);

	rom_store roms (
		.clock_48 (clock_48),
		.wr_valid (wr_valid),
		.wr       (wr),
		.cpu_addr (cpu_addr),
		.cpu_data (cpu_data),
		.spr_addr (spr_addr),
		.spr_data (spr_data)
	);

	////////////////////////////////////////////////////////////
	// Cabinet controls

	stream_skid #(.payload_t(key_event_t)) key_skid (
		.clock_48  (clock_48),
		.rst       (rst),
		.in_valid  (key_valid),
		.in_ready  (key_ready),
		.in_data   (key),
		.out_valid (key_q_valid),
		.out_ready (key_q_ready),
		.out_data  (key_q)
	);

	key_decoder keys (
		.clock_48  (clock_48),
		.rst       (rst),
		.key_valid (key_q_valid),
		.key_ready (key_q_ready),
		.key       (key_q),
		.buttons   (buttons)
	);

	cabinet_inputs cab (
		.clock_48   (clock_48),
		.rst        (rst),
		.buttons    (buttons),
		.joy0       (joy0),
		.joy1       (joy1),
		.status     (status),
		.menu_reset (menu_reset),
		.download   (download),
		.rom_loaded (rom_loaded),
		.cabinet    (cabinet),
		.core_reset (core_reset)
	);

	video_timing video (
		.clock_48  (clock_48),
		.rst       (rst),
		.pixel_rgb (pixel_rgb),
		.pclk_en   (pclk_en),
		.hpos      (hpos),
		.vpos      (vpos),
		.hblank    (hblank),
		.vblank    (vblank),
		.hsync     (hsync),
		.vsync     (vsync),
		.rgb_out   (rgb_out)
	);

endmodule

// ==== cabinet_inputs.sv ====
// Builds the core input ports from keys and joysticks, decodes DIP switches, drives core reset
`timescale 1ns/1ps

module cabinet_inputs (
	input  logic                 clock_48,
	input  logic                 rst,
	input  arcade_pkg::buttons_t buttons,
	input  logic [7:0]           joy0,
	input  logic [7:0]           joy1,
	input  logic [31:0]          status,
	input  logic                 menu_reset,
	input  logic                 download,
	input  logic                 rom_loaded,
	output arcade_pkg::cabinet_t cabinet,
	output logic                 core_reset
);
	logic       rotate;
	logic [5:0] joy_any;
	logic       m_up;
	logic       m_down;
	logic       m_left;
	logic       m_right;
	logic       m_fire1;
	logic       m_fire2;
	logic [5:0] player;

	assign rotate  = status[2];
	assign joy_any = joy0[5:0] | joy1[5:0]; // Either stick drives both players

	////////////////////////////////////////////////////////////
	// Direction mapping, rotated for a sideways monitor

	assign m_up    = rotate ? buttons.right | joy_any[0] : buttons.up    | joy_any[3];
	assign m_down  = rotate ? buttons.left  | joy_any[1] : buttons.down  | joy_any[2];
	assign m_left  = rotate ? buttons.up    | joy_any[3] : buttons.left  | joy_any[1];
	assign m_right = rotate ? buttons.down  | joy_any[2] : buttons.right | joy_any[0];
	assign m_fire1 = buttons.fire1 | joy_any[4];
	assign m_fire2 = buttons.fire2 | joy_any[5];

	assign player = {m_fire2, m_fire1, m_left, m_down, m_right, m_up};

	always_ff @(posedge clock_48) begin
		cabinet.inp0 <= player;
		cabinet.inp1 <= player;
		cabinet.inp2 <= {buttons.coin, buttons.start2, buttons.start1};
		// Demo sound, difficulty, extend, lives, all active low
		cabinet.dsw0 <= {~status[14], ~status[13:12], ~status[11:10], 1'b0, ~status[9:8]};
	end

	// Core held until a full ROM is in place
	always_ff @(posedge clock_48) begin
		if (rst) begin
			core_reset <= 1'b1;
		end else begin
			core_reset <= status[0] | menu_reset | download | !rom_loaded;
		end
	end

endmodule

// ==== key_decoder.sv ====
// Holds the pressed state of the nine cabinet keys from keyboard scancode events
`timescale 1ns/1ps

module key_decoder (
	input  logic                   clock_48,
	input  logic                   rst,
	input  logic                   key_valid,
	output logic                   key_ready,
	input  arcade_pkg::key_event_t key,
	output arcade_pkg::buttons_t   buttons
);
	import arcade_pkg::*;

	assign key_ready = 1'b1; // One event per cycle

	always_ff @(posedge clock_48) begin
		if (rst) begin
			buttons <= '0;
		end else if (key_valid) begin
			case (key.code)
				key_up:     buttons.up     <= key.pressed;
				key_down:   buttons.down   <= key.pressed;
				key_left:   buttons.left   <= key.pressed;
				key_right:  buttons.right  <= key.pressed;
				key_fire1:  buttons.fire1  <= key.pressed;
				key_fire2:  buttons.fire2  <= key.pressed;
				key_start1: buttons.start1 <= key.pressed;
				key_start2: buttons.start2 <= key.pressed;
				key_coin:   buttons.coin   <= key.pressed;
				default: begin
					// Other keys leave the cabinet alone
				end
			endcase
		end
	end

endmodule

// ==== rom_loader.sv ====
// Maps the ROM download byte stream onto region-tagged word writes and flags a finished load
`timescale 1ns/1ps

module rom_loader (
	input  logic                   clock_48,
	input  logic                   rst,
	input  logic                   download,
	input  logic                   byte_valid,
	output logic                   byte_ready,
	input  arcade_pkg::rom_byte_t  byte_in,
	output logic                   wr_valid,
	output arcade_pkg::rom_write_t wr,
	output logic                   rom_loaded
);
	import arcade_pkg::*;

	logic        take;
	logic [17:0] main_off;
	logic [17:0] spr_off;
	logic        in_main;
	logic        in_sprite;
	logic [17:0] offset;
	logic        download_d;
	logic        any_written;

	assign byte_ready = download; // Bytes wait in the FIFO otherwise
	assign take       = byte_valid && download;

	// Unsigned offsets wrap below the base
	assign main_off  = byte_in.addr - 18'(main_base);
	assign spr_off   = byte_in.addr - 18'(sprite_base);
	assign in_main   = main_off < 18'(main_size);
	assign in_sprite = spr_off < 18'(sprite_size);
	assign offset    = in_sprite ? spr_off : main_off;

	always_ff @(posedge clock_48) begin
		if (rst) begin
			wr_valid    <= 1'b0;
			download_d  <= 1'b0;
			any_written <= 1'b0;
			rom_loaded  <= 1'b0;
		end else begin
			wr_valid   <= take && (in_main || in_sprite); // Char and palette bytes dropped
			download_d <= download;
			if (take && (in_main || in_sprite)) any_written <= 1'b1;
			if (download_d && !download && any_written) rom_loaded <= 1'b1;
		end
	end

	always_ff @(posedge clock_48) begin
		if (take) begin
			wr.region <= in_sprite;
			wr.addr   <= offset[15:1];
			wr.data   <= {byte_in.data, byte_in.data};
			wr.be     <= {byte_in.addr[0], !byte_in.addr[0]}; // Odd byte to high lane
		end
	end

	// Region-relative word address of the next write fits the ROM arrays
	a_addr_range: assert property (@(posedge clock_48) disable iff (rst)
		take && (in_main || in_sprite) |-> 32'(offset[17:1]) < rom_words);

endmodule

// ==== rom_store.sv ====
// On-chip main program and sprite ROMs, loaded by word writes and read by the game core
`timescale 1ns/1ps

module rom_store (
	input  logic                   clock_48,
	input  logic                   wr_valid,
	input  arcade_pkg::rom_write_t wr,
	input  logic [15:0]            cpu_addr,
	output logic [7:0]             cpu_data,
	input  logic [14:0]            spr_addr,
	output logic [15:0]            spr_data
);
	import arcade_pkg::*;

	logic [15:0] main_mem [rom_words];
	logic [15:0] spr_mem  [rom_words];
	logic [15:0] main_q;
	logic        cpu_hi;

	////////////////////////////////////////////////////////////
	// Main program ROM

	always_ff @(posedge clock_48) begin
		if (wr_valid && !wr.region) begin
			if (wr.be[0]) main_mem[wr.addr][7:0] <= wr.data[7:0];
			if (wr.be[1]) main_mem[wr.addr][15:8] <= wr.data[15:8];
		end
		main_q <= main_mem[cpu_addr[15:1]]; // Old word on a colliding write
		cpu_hi <= cpu_addr[0];
	end

	// CPU bus is 8 bits wide
	assign cpu_data = cpu_hi ? main_q[15:8] : main_q[7:0];

	////////////////////////////////////////////////////////////
	// Sprite graphics ROM

	always_ff @(posedge clock_48) begin
		if (wr_valid && wr.region) begin
			if (wr.be[0]) spr_mem[wr.addr][7:0] <= wr.data[7:0];
			if (wr.be[1]) spr_mem[wr.addr][15:8] <= wr.data[15:8];
		end
		spr_data <= spr_mem[spr_addr];
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the arcade shell testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_arcade_shell \
	-f sources.f \
	-o sim_arcade_shell

./obj_dir/sim_arcade_shell

// ==== sources.f ====
arcade_pkg.sv
stream_skid.sv
rom_loader.sv
rom_store.sv
key_decoder.sv
cabinet_inputs.sv
video_timing.sv
arcade_shell.sv
tb_arcade_shell.sv

// ==== stream_skid.sv ====
// Two-entry valid/ready FIFO placed on each incoming event stream of the shell
`timescale 1ns/1ps

module stream_skid #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clock_48,
	input  logic     rst,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);
	payload_t   slot [2];
	logic       wr_ptr;
	logic       rd_ptr;
	logic [1:0] count;
	logic       push;
	logic       pop;

	assign in_ready  = count != 2'd2;
	assign out_valid = count != 2'd0;
	assign out_data  = slot[rd_ptr];
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	always_ff @(posedge clock_48) begin
		if (rst) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end else begin
			if (push) wr_ptr <= !wr_ptr;
			if (pop) rd_ptr <= !rd_ptr;
			count <= count + {1'b0, push} - {1'b0, pop};
		end
	end

	always_ff @(posedge clock_48) begin
		if (push) slot[wr_ptr] <= in_data;
	end

	// Occupancy never passes the two slots
	a_no_overflow: assert property (@(posedge clock_48) disable iff (rst)
		count <= 2'd2);

	a_head_hold: assert property (@(posedge clock_48) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data)); // Head waits intact

endmodule

// ==== tb_arcade_shell.sv ====
// Self-checking testbench for the arcade shell top level, built and run by the Verilator script
`timescale 1ns/1ps

module tb_arcade_shell;
	import arcade_pkg::*;

	localparam int frame_cycles  = h_total * v_total * pclk_div;
	localparam int budget_cycles = 2 * frame_cycles + 20000; // Two frames plus the other phases
	// Indexed by buttons_t bit, coin at bit 0
	localparam logic [7:0] key_codes [9] = '{8'h76, 8'h06, 8'h05, 8'h11, 8'h29,
		8'h74, 8'h6B, 8'h72, 8'h75};
	localparam logic [17:0] block_base [4] = '{18'h00000, 18'h0FF80, 18'h10000, 18'h1FF80};

	logic        clock_48 = 1'b0;
	logic        rst;
	logic        download;
	logic        byte_valid;
	logic        byte_ready;
	rom_byte_t   byte_in;
	logic        key_valid;
	logic        key_ready;
	key_event_t  key;
	logic [7:0]  joy0;
	logic [7:0]  joy1;
	logic [31:0] status;
	logic        menu_reset;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_data;
	logic [14:0] spr_addr;
	logic [15:0] spr_data;
	logic [11:0] pixel_rgb;
	cabinet_t    cabinet;
	logic        core_reset;
	logic        pclk_en;
	logic [8:0]  hpos;
	logic [8:0]  vpos;
	logic        hblank;
	logic        vblank;
	logic        hsync;
	logic        vsync;
	logic [11:0] rgb_out;

	logic [7:0]  ref_img [0:262143]; // Download image as sent
	logic [31:0] rng;
	logic        model_written;
	logic        cpu_chk;
	logic        spr_chk;
	logic        cpu_chk_d;
	logic        spr_chk_d;
	logic [7:0]  cpu_exp;
	logic [15:0] spr_exp;
	buttons_t    btn_m;
	buttons_t    btn_d;
	cabinet_t    exp_cab;
	logic        dl_d;
	logic        loaded_m;
	logic        exp_reset;
	logic [2:0]  held_cnt;
	logic [2:0]  div_m;
	logic [8:0]  h_m;
	logic [8:0]  v_m;
	logic [3:0]  exp_sync;
	logic [11:0] exp_rgb;
	logic        hs_q;
	logic        seen_hs;
	logic [31:0] hs_gap;
	logic        hs_rise;

	arcade_shell dut (.*);

	initial begin
		forever #20 clock_48 = ~clock_48;
	end

	////////////////////////////////////////////////////////////
	// Reference model

	function automatic cabinet_t predict_cabinet(input buttons_t b, input logic [7:0] j0,
		input logic [7:0] j1, input logic [31:0] st);
		logic [3:0] d;
		logic [5:0] p;
		cabinet_t   c;
		d = {b.up, b.down, b.left, b.right} | j0[3:0] | j1[3:0]; // Joystick bit order
		if (st[2])
			p = {b.fire2 | j0[5] | j1[5], b.fire1 | j0[4] | j1[4], d[3], d[1], d[2], d[0]};
		else
			p = {b.fire2 | j0[5] | j1[5], b.fire1 | j0[4] | j1[4], d[1], d[2], d[0], d[3]};
		c.inp0 = p;
		c.inp1 = p;
		c.inp2 = {b.coin, b.start2, b.start1};
		c.dsw0 = {~st[14:10], 1'b0, ~st[9:8]};
		return c;
	endfunction

	always @(posedge clock_48) begin
		if (rst) begin
			btn_m    <= '0;
			btn_d    <= '0;
			dl_d     <= 1'b0;
			loaded_m <= 1'b0;
			held_cnt <= 3'd0;
		end else begin
			if (key_valid && key_ready) begin
				for (int i = 0; i < 9; i++)
					if (key.code == key_codes[i]) btn_m[i] <= key.pressed;
			end
			btn_d <= btn_m; // Skid stage
			dl_d  <= download;
			if (dl_d && !download && model_written) loaded_m <= 1'b1;
			if (download) held_cnt <= 3'd0;
			else if (byte_valid && byte_ready && held_cnt != 3'd7) held_cnt <= held_cnt + 3'd1;
		end
		exp_cab   <= predict_cabinet(btn_d, joy0, joy1, status);
		exp_reset <= rst | status[0] | menu_reset | download | !loaded_m;
		cpu_exp   <= ref_img[{2'b00, cpu_addr}];
		spr_exp   <= {ref_img[{2'b01, spr_addr, 1'b1}], ref_img[{2'b01, spr_addr, 1'b0}]};
		cpu_chk_d <= cpu_chk;
		spr_chk_d <= spr_chk;
	end

	// Video timing model, one pixel per 8 clocks
	always @(posedge clock_48) begin
		if (rst) begin
			div_m    <= 3'd0;
			h_m      <= 9'd0;
			v_m      <= 9'd0;
			exp_sync <= 4'd0;
			exp_rgb  <= 12'd0;
			hs_gap   <= 32'd0;
			seen_hs  <= 1'b0;
		end else begin
			div_m <= (div_m == 3'd7) ? 3'd0 : div_m + 3'd1;
			if (div_m == 3'd7) begin
				exp_sync <= {h_m >= 9'(h_active), v_m >= 9'(v_active),
					h_m >= 9'(h_sync_start) && h_m < 9'(h_sync_end),
					v_m >= 9'(v_sync_start) && v_m < 9'(v_sync_end)};
				exp_rgb <= (h_m >= 9'(h_active) || v_m >= 9'(v_active)) ? 12'd0 : pixel_rgb;
				h_m <= (h_m == 9'(h_total - 1)) ? 9'd0 : h_m + 9'd1;
				if (h_m == 9'(h_total - 1)) v_m <= (v_m == 9'(v_total - 1)) ? 9'd0 : v_m + 9'd1;
			end
			hs_gap  <= (hsync && !hs_q) ? 32'd1 : hs_gap + 32'd1;
			seen_hs <= seen_hs | (hsync && !hs_q);
		end
		hs_q <= hsync;
	end

	assign hs_rise = hsync && !hs_q;

	////////////////////////////////////////////////////////////
	// Checks, sampled on the falling edge

	task automatic stop_run();
		$display("test failed");
		$fatal(1);
	endtask

	task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("Fail %s: got %h, expected %h", name, got, exp);
		stop_run();
	endtask

	task automatic report_error(input string what);
		$display("%s", what);
		stop_run();
	endtask

	a_cpu_read: assert property (@(negedge clock_48) disable iff (rst)
		cpu_chk_d |-> cpu_data == cpu_exp)
		else report_value("cpu_data", {24'd0, cpu_data}, {24'd0, cpu_exp});
	a_spr_read: assert property (@(negedge clock_48) disable iff (rst)
		spr_chk_d |-> spr_data == spr_exp)
		else report_value("spr_data", {16'd0, spr_data}, {16'd0, spr_exp});
	// Ready drops once two bytes wait with download low
	a_backpressure: assert property (@(negedge clock_48) disable iff (rst)
		byte_ready == (held_cnt < 3'd2))
		else report_value("byte_ready", {31'd0, byte_ready}, {31'd0, held_cnt < 3'd2});
	a_key_ready: assert property (@(negedge clock_48) disable iff (rst) key_ready)
		else report_value("key_ready", {31'd0, key_ready}, 32'd1);
	a_core_reset: assert property (@(negedge clock_48) disable iff (rst)
		core_reset == exp_reset)
		else report_value("core_reset", {31'd0, core_reset}, {31'd0, exp_reset});
	a_cabinet: assert property (@(negedge clock_48) disable iff (rst) cabinet == exp_cab)
		else report_value("cabinet", {9'd0, cabinet}, {9'd0, exp_cab});
	a_pclk: assert property (@(negedge clock_48) disable iff (rst) pclk_en == (div_m == 3'd7))
		else report_value("pclk_en", {31'd0, pclk_en}, {31'd0, div_m == 3'd7});
	a_beam: assert property (@(negedge clock_48) disable iff (rst) hpos == h_m && vpos == v_m)
		else report_value("hpos_vpos", {14'd0, hpos, vpos}, {14'd0, h_m, v_m});
	a_sync: assert property (@(negedge clock_48) disable iff (rst)
		{hblank, vblank, hsync, vsync} == exp_sync)
		else report_value("blank_sync", {28'd0, hblank, vblank, hsync, vsync}, {28'd0, exp_sync});
	a_rgb: assert property (@(negedge clock_48) disable iff (rst) rgb_out == exp_rgb)
		else report_value("rgb_out", {20'd0, rgb_out}, {20'd0, exp_rgb});
	a_hs_period: assert property (@(negedge clock_48) disable iff (rst)
		hs_rise && seen_hs |-> hs_gap == 32'(h_total * pclk_div))
		else report_value("hsync_period", hs_gap, 32'(h_total * pclk_div));

	////////////////////////////////////////////////////////////
	// Stimulus

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng = xorshift(rng);
		return rng;
	endfunction

	task automatic next_cycle();
		@(posedge clock_48);
		#1;
	endtask

	task automatic offer_byte(input logic [17:0] addr, input logic [7:0] data);
		byte_in.addr = addr;
		byte_in.data = data;
		byte_valid   = 1'b1;
		if (addr < 18'h20000) begin
			ref_img[addr] = data;
			model_written = 1'b1;
		end
	endtask

	task automatic wait_byte_accept();
		logic taken;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clock_48);
			taken = byte_ready;
			next_cycle();
		end
		byte_valid = 1'b0;
	endtask

	task automatic send_key(input logic pressed, input logic [7:0] code);
		logic taken;
		key.pressed = pressed;
		key.code    = code;
		key_valid   = 1'b1;
		taken       = 1'b0;
		while (!taken) begin
			@(negedge clock_48);
			taken = key_ready;
			next_cycle();
		end
		key_valid = 1'b0;
	endtask

	task automatic read_main(input logic [15:0] addr);
		cpu_addr = addr;
		cpu_chk  = 1'b1;
		next_cycle();
		cpu_chk = 1'b0;
	endtask

	task automatic read_sprite(input logic [14:0] word);
		spr_addr = word;
		spr_chk  = 1'b1;
		next_cycle();
		spr_chk = 1'b0;
	endtask

	initial begin
		repeat (budget_cycles) @(posedge clock_48);
		report_error("Timeout: the test sequence did not finish in time");
	end

	initial begin
		logic [31:0] r;
		logic [17:0] a;
		logic [7:0]  code;
		rst           = 1'b1;
		rng           = 32'hd212_1bd3;
		download      = 1'b0;
		byte_valid    = 1'b0;
		byte_in       = '0;
		key_valid     = 1'b0;
		key           = '0;
		joy0          = 8'd0;
		joy1          = 8'd0;
		status        = 32'd0;
		menu_reset    = 1'b0;
		cpu_addr      = 16'd0;
		spr_addr      = 15'd0;
		pixel_rgb     = 12'd0;
		model_written = 1'b0;
		cpu_chk       = 1'b0;
		spr_chk       = 1'b0;
		repeat (16) @(posedge clock_48);
		#1;
		rst = 1'b0;
		repeat (4) next_cycle();

		// Download into both regions, then bytes above them that must be dropped
		download = 1'b1;
		for (int b = 0; b < 4; b++) begin
			for (int i = 0; i < 128; i++) begin
				r = next_random();
				offer_byte(block_base[b] + 18'(i), r[15:8]);
				wait_byte_accept();
				repeat (r[1:0]) next_cycle();
			end
		end
		for (int i = 0; i < 32; i++) begin
			r = next_random();
			offer_byte(18'h20000 + 18'(i), r[15:8]);
			wait_byte_accept();
		end
		repeat (4) next_cycle();
		download = 1'b0;
		repeat (4) next_cycle();
		for (int b = 0; b < 2; b++)
			for (int i = 0; i < 128; i++) begin
				a = block_base[b] + 18'(i);
				read_main(a[15:0]);
			end
		for (int b = 2; b < 4; b++)
			for (int w = 0; w < 64; w++) read_sprite(block_base[b][15:1] + 15'(w));

		// Back-pressure with download low, third byte has to wait
		r = next_random();
		offer_byte(18'h08000, r[7:0]);
		wait_byte_accept();
		offer_byte(18'h08001, r[15:8]);
		wait_byte_accept();
		offer_byte(18'h08002, r[23:16]);
		repeat (6) next_cycle();
		download = 1'b1;
		wait_byte_accept();
		repeat (4) next_cycle();
		download = 1'b0;
		repeat (4) next_cycle();
		for (int i = 0; i < 3; i++) read_main(16'h8000 + 16'(i));

		// Controls, DIP switches and reset sources, without and with rotation
		for (int rot = 0; rot < 2; rot++) begin
			for (int n = 0; n < 60; n++) begin
				r = next_random();
				status     = next_random();
				status[2]  = rot[0];
				status[0]  = r[4:2] == 3'd0;
				menu_reset = r[7:5] == 3'd0;
				joy0       = r[15:8] & r[23:16] & r[31:24]; // Sparse stick bits
				r = next_random();
				joy1 = r[23:16] & r[31:24] & r[15:8];
				if (r[3:0] < 4'd9) code = key_codes[r[3:0]];
				else code = r[4] ? 8'h1C : 8'h5A; // Not a cabinet key
				send_key(r[8], code);
				repeat (r[10:9]) next_cycle();
			end
		end
		status     = 32'd0;
		menu_reset = 1'b0;
		joy0       = 8'd0;
		joy1       = 8'd0;

		// Two frames of random pixels
		for (int n = 0; n < 2 * frame_cycles; n++) begin
			r = next_random();
			pixel_rgb = r[11:0];
			next_cycle();
		end
		$display("test passed");
		$finish;
	end

endmodule

// ==== video_timing.sv ====
// Generates the 6 MHz pixel enable, beam counters, blanking, sync and blanked RGB for the core
`timescale 1ns/1ps

module video_timing (
	input  logic        clock_48,
	input  logic        rst,
	input  logic [11:0] pixel_rgb,
	output logic        pclk_en,
	output logic [8:0]  hpos,
	output logic [8:0]  vpos,
	output logic        hblank,
	output logic        vblank,
	output logic        hsync,
	output logic        vsync,
	output logic [11:0] rgb_out
);
	import arcade_pkg::*;

	logic [2:0] div;
	logic       hb_now;
	logic       vb_now;

	assign pclk_en = div == 3'(pclk_div - 1);
	assign hb_now  = hpos >= 9'(h_active);
	assign vb_now  = vpos >= 9'(v_active);

	always_ff @(posedge clock_48) begin
		if (rst) begin
			div <= 3'd0;
		end else begin
			div <= pclk_en ? 3'd0 : div + 3'd1;
		end
	end

	////////////////////////////////////////////////////////////
	// Beam position

	always_ff @(posedge clock_48) begin
		if (rst) begin
			hpos <= '0;
			vpos <= '0;
		end else if (pclk_en) begin
			if (hpos == 9'(h_total - 1)) begin
				hpos <= '0;
				vpos <= (vpos == 9'(v_total - 1)) ? '0 : vpos + 9'd1;
			end else begin
				hpos <= hpos + 9'd1;
			end
		end
	end

	// Outputs track the position sampled on the same enable
	always_ff @(posedge clock_48) begin
		if (rst) begin
			hblank  <= 1'b0;
			vblank  <= 1'b0;
			hsync   <= 1'b0;
			vsync   <= 1'b0;
			rgb_out <= '0;
		end else if (pclk_en) begin
			hblank  <= hb_now;
			vblank  <= vb_now;
			hsync   <= hpos >= 9'(h_sync_start) && hpos < 9'(h_sync_end);
			vsync   <= vpos >= 9'(v_sync_start) && vpos < 9'(v_sync_end);
			rgb_out <= (hb_now || vb_now) ? 12'd0 : pixel_rgb;
		end
	end

	a_beam_range: assert property (@(posedge clock_48) disable iff (rst)
		hpos < 9'(h_total) && vpos < 9'(v_total));

	// Sync edge lands one pixel ahead of the counter
	a_hsync_align: assert property (@(posedge clock_48) disable iff (rst)
		$rose(hsync) |-> hpos == 9'(h_sync_start + 1));

endmodule
